/* source/matmul_pkg.sv */
package matmul_pkg;

  ////////////////////////////////////////
  // Array geometry and bus widths
  ////////////////////////////////////////

  // Matrix edge length, also the number of lanes per memory word
  localparam int MM_N = 4;
  localparam int DATA_W = 8;
  localparam int ADDR_W = 11;
  localparam int STRIDE_W = 8;
  localparam int CNT_W = 8;
  // Bits needed to index one column or one inner step
  localparam int COL_W = $clog2(MM_N);

  ////////////////////////////////////////
  // Pipeline depths and run schedule
  ////////////////////////////////////////

  // Operand memories return data one cycle after the address
  localparam int MEM_LATENCY = 1;
  // Operand flop, product register, accumulator
  localparam int MAC_STAGES = 3;
  // Count at which the last product has landed in the far corner PE
  localparam int LATCH_COUNT = 3 * MM_N - 2 + MAC_STAGES;
  // Count that fires done, one cycle later it shows on the port
  localparam int DONE_COUNT = 4 * MM_N - 3 + MAC_STAGES;

  typedef logic signed [DATA_W-1:0] elem_t;
  typedef logic [MM_N-1:0] mask_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [STRIDE_W-1:0] stride_t;

  // One memory word, seen either as raw bits or as signed lanes
  // Lane 0 sits in the low byte
  typedef union packed {
    logic [MM_N*DATA_W-1:0] flat;
    elem_t [MM_N-1:0] lane;
  } lane_word_u;

endpackage

/* source/matmul_if.sv */
`timescale 1ns/1ps

// Skewed operands entering the PE grid
// A lanes go in at the left edge, B lanes at the top edge
// An all-zero lane stands for an empty slot
interface operand_if;

  matmul_pkg::elem_t [matmul_pkg::MM_N-1:0] a_row;
  matmul_pkg::elem_t [matmul_pkg::MM_N-1:0] b_col;

  modport feeder (
    output a_row,
    output b_col
  );

  modport array (
    input a_row,
    input b_col
  );

endinterface

// Accumulator snapshot of the whole grid, indexed [row][column]
interface result_if;

  matmul_pkg::elem_t [matmul_pkg::MM_N-1:0][matmul_pkg::MM_N-1:0] c;

  modport array (
    output c
  );

  modport drain (
    input c
  );

endinterface

/* source/mm_sequencer.sv */
`timescale 1ns/1ps

module mm_sequencer (
  input  logic               clk,
  input  logic               reset,
  input  logic               i_start,
  output matmul_pkg::cnt_t   o_cnt,
  output logic               o_latch,
  output logic               o_done
);

  matmul_pkg::cnt_t cnt_q;
  logic done_q;

  ////////////////////////////////////////
  // Run counter
  ////////////////////////////////////////

  // Count is 0 on the first cycle with start high
  // It parks one past DONE_COUNT so the run fires only once
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      cnt_q <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= (cnt_q == matmul_pkg::DONE_COUNT);
      if (cnt_q <= matmul_pkg::DONE_COUNT) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign o_cnt = cnt_q;

  // Grid results are final at this count, drain grabs them here
  assign o_latch = (cnt_q == matmul_pkg::LATCH_COUNT);

  // Single-cycle pulse, the counter has moved past DONE_COUNT by now
  assign o_done = done_q;

endmodule

/* source/operand_feeder.sv */
`timescale 1ns/1ps

module operand_feeder (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  matmul_pkg::cnt_t       i_cnt,
  input  matmul_pkg::addr_t      i_addr_a,
  input  matmul_pkg::addr_t      i_addr_b,
  input  matmul_pkg::stride_t    i_stride_a,
  input  matmul_pkg::stride_t    i_stride_b,
  input  matmul_pkg::lane_word_u i_data_a,
  input  matmul_pkg::lane_word_u i_data_b,
  input  matmul_pkg::mask_t      i_mask_a_rows,
  input  matmul_pkg::mask_t      i_mask_inner,
  input  matmul_pkg::mask_t      i_mask_b_cols,
  output matmul_pkg::addr_t      o_addr_a,
  output matmul_pkg::addr_t      o_addr_b,
  operand_if.feeder              ops
);

  // Side 0 is the A memory, side 1 is the B memory
  matmul_pkg::addr_t base [2];
  matmul_pkg::stride_t stride [2];
  matmul_pkg::lane_word_u word [2];
  matmul_pkg::mask_t lane_mask [2];

  logic run_clear;
  matmul_pkg::addr_t addr_q [2];
  logic [matmul_pkg::MEM_LATENCY-1:0] ret_vld_q;
  logic [matmul_pkg::COL_W-1:0] ret_idx_q [matmul_pkg::MEM_LATENCY];
  logic word_ok;
  matmul_pkg::elem_t [matmul_pkg::MM_N-1:0] qual [2];
  matmul_pkg::elem_t skew_q [2][matmul_pkg::MM_N][matmul_pkg::MM_N-1];
  matmul_pkg::elem_t [matmul_pkg::MM_N-1:0] fed [2];

  assign run_clear = reset || !i_start;

  // Gather both sides so A and B share one datapath
  always_comb begin
    base[0] = i_addr_a;
    base[1] = i_addr_b;
    stride[0] = i_stride_a;
    stride[1] = i_stride_b;
    word[0] = i_data_a;
    word[1] = i_data_b;
    lane_mask[0] = i_mask_a_rows;
    lane_mask[1] = i_mask_b_cols;
  end

  ////////////////////////////////////////
  // Fetch addresses and index tracking
  ////////////////////////////////////////

  // Idle value is the base, so index 0 is on the bus at count 0
  // Steps on counts 0..MM_N-2, holds on the last fetch afterwards
  always_ff @(posedge clk) begin
    if (run_clear) begin
      for (int s = 0; s < 2; s++) begin
        addr_q[s] <= base[s];
      end
    end else if (i_cnt < matmul_pkg::MM_N - 1) begin
      for (int s = 0; s < 2; s++) begin
        addr_q[s] <= addr_q[s] + matmul_pkg::addr_t'(stride[s]);
      end
    end
  end

  // Follow each fetch through the memory latency
  // so the returning word knows its inner index
  always_ff @(posedge clk) begin
    if (run_clear) begin
      ret_vld_q <= '0;
      for (int l = 0; l < matmul_pkg::MEM_LATENCY; l++) begin
        ret_idx_q[l] <= '0;
      end
    end else begin
      ret_vld_q[0] <= (i_cnt < matmul_pkg::MM_N);
      ret_idx_q[0] <= i_cnt[matmul_pkg::COL_W-1:0];
      for (int l = 1; l < matmul_pkg::MEM_LATENCY; l++) begin
        ret_vld_q[l] <= ret_vld_q[l-1];
        ret_idx_q[l] <= ret_idx_q[l-1];
      end
    end
  end

  // Word is inside the fetch window and its inner index is enabled
  assign word_ok = ret_vld_q[matmul_pkg::MEM_LATENCY-1] &&
                   i_mask_inner[ret_idx_q[matmul_pkg::MEM_LATENCY-1]];

  // Blank masked A rows and masked B columns lane by lane
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      for (int r = 0; r < matmul_pkg::MM_N; r++) begin
        qual[s][r] = (word_ok && lane_mask[s][r]) ? word[s].lane[r] : '0;
      end
    end
  end

  ////////////////////////////////////////
  // Diagonal skew
  ////////////////////////////////////////

  // Every lane shifts through its own line, lane r taps after r flops
  always_ff @(posedge clk) begin
    if (run_clear) begin
      for (int s = 0; s < 2; s++) begin
        for (int r = 0; r < matmul_pkg::MM_N; r++) begin
          for (int d = 0; d < matmul_pkg::MM_N - 1; d++) begin
            skew_q[s][r][d] <= '0;
          end
        end
      end
    end else begin
      for (int s = 0; s < 2; s++) begin
        for (int r = 0; r < matmul_pkg::MM_N; r++) begin
          skew_q[s][r][0] <= qual[s][r];
          for (int d = 1; d < matmul_pkg::MM_N - 1; d++) begin
            skew_q[s][r][d] <= skew_q[s][r][d-1];
          end
        end
      end
    end
  end

  // Lane 0 goes straight in, with no delay
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      for (int r = 0; r < matmul_pkg::MM_N; r++) begin
        if (r == 0) begin
          fed[s][r] = qual[s][r];
        end else begin
          fed[s][r] = skew_q[s][r][r-1];
        end
      end
    end
  end

  assign ops.a_row = fed[0];
  assign ops.b_col = fed[1];
  assign o_addr_a = addr_q[0];
  assign o_addr_b = addr_q[1];

endmodule

/* source/mac_pe.sv */
`timescale 1ns/1ps

module mac_pe (
  input  logic              clk,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_c
);

  logic signed [2*matmul_pkg::DATA_W-1:0] prod_q;
  logic prod_neg;
  logic prod_ovf;
  matmul_pkg::elem_t prod_sat;
  matmul_pkg::elem_t acc_q;

  // Stage 1 operand flops also feed the right and lower neighbours
  // Stage 2 holds the full signed product
  // Stage 3 folds the saturated product into the accumulator
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_a <= '0;
      o_b <= '0;
      prod_q <= '0;
      acc_q <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
      prod_q <= o_a * o_b;
      // 8-bit add, wraps on overflow
      acc_q <= acc_q + prod_sat;
    end
  end

  ////////////////////////////////////////
  // Product saturation
  ////////////////////////////////////////

  assign prod_neg = prod_q[2*matmul_pkg::DATA_W-1];

  // Fits in 8 bits only if the top DATA_W+1 bits are all sign copies
  assign prod_ovf = (prod_q[2*matmul_pkg::DATA_W-1:matmul_pkg::DATA_W-1] !=
                     {(matmul_pkg::DATA_W+1){prod_neg}});

  // Clamp to -128 or 127 depending on sign
  assign prod_sat = prod_ovf ? {prod_neg, {(matmul_pkg::DATA_W-1){~prod_neg}}}
                             : prod_q[matmul_pkg::DATA_W-1:0];

  assign o_c = acc_q;

endmodule

/* source/pe_array.sv */
`timescale 1ns/1ps

module pe_array (
  input  logic      clk,
  input  logic      reset,
  input  logic      i_start,
  operand_if.array  ops,
  result_if.array   res
);

  logic run_clear;
  // Forwarded operand leaving PE [i][j] to the right and downward
  matmul_pkg::elem_t a_link [matmul_pkg::MM_N][matmul_pkg::MM_N];
  matmul_pkg::elem_t b_link [matmul_pkg::MM_N][matmul_pkg::MM_N];

  // Dropping start wipes every accumulator, same as reset
  assign run_clear = reset || !i_start;

  ////////////////////////////////////////
  // Systolic grid
  ////////////////////////////////////////

  for (genvar i = 0; i < matmul_pkg::MM_N; i++) begin : g_row
    for (genvar j = 0; j < matmul_pkg::MM_N; j++) begin : g_col
      matmul_pkg::elem_t a_in;
      matmul_pkg::elem_t b_in;

      // Left column takes A from the feeder, others from the left PE
      if (j == 0) begin : g_a_edge
        assign a_in = ops.a_row[i];
      end else begin : g_a_link
        assign a_in = a_link[i][j-1];
      end

      // Top row takes B from the feeder, others from the PE above
      if (i == 0) begin : g_b_edge
        assign b_in = ops.b_col[j];
      end else begin : g_b_link
        assign b_in = b_link[i-1][j];
      end

      mac_pe u_pe (
        .clk     (clk),
        .i_clear (run_clear),
        .i_a     (a_in),
        .i_b     (b_in),
        .o_a     (a_link[i][j]),
        .o_b     (b_link[i][j]),
        .o_c     (res.c[i][j])
      );
    end
  end

endmodule

/* source/result_drain.sv */
`timescale 1ns/1ps

module result_drain (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_start,
  input  logic                   i_latch,
  input  matmul_pkg::addr_t      i_addr_c,
  input  matmul_pkg::stride_t    i_stride_c,
  output matmul_pkg::addr_t      o_addr_c,
  output matmul_pkg::lane_word_u o_data_c,
  output logic                   o_c_valid,
  result_if.drain                res
);

  // Snapshot of C taken on the latch pulse
  matmul_pkg::elem_t [matmul_pkg::MM_N-1:0][matmul_pkg::MM_N-1:0] hold_q;
  // Next column to send, wraps to 0 after the last one
  logic [matmul_pkg::COL_W-1:0] col_q;

  always_ff @(posedge clk) begin
    if (i_latch) begin
      hold_q <= res.c;
    end
  end

  ////////////////////////////////////////
  // Column beats
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_c_valid <= 1'b0;
      o_addr_c <= '0;
      o_data_c.flat <= '0;
      col_q <= '0;
    end else if (i_latch) begin
      // Column 0 comes straight off the grid
      o_c_valid <= 1'b1;
      o_addr_c <= i_addr_c;
      for (int i = 0; i < matmul_pkg::MM_N; i++) begin
        o_data_c.lane[i] <= res.c[i][0];
      end
      col_q <= 1'b1;
    end else if (o_c_valid && (col_q != '0)) begin
      // Remaining columns from the snapshot, ascending addresses
      o_addr_c <= o_addr_c + matmul_pkg::addr_t'(i_stride_c);
      for (int i = 0; i < matmul_pkg::MM_N; i++) begin
        o_data_c.lane[i] <= hold_q[i][col_q];
      end
      col_q <= col_q + 1'b1;
    end else begin
      // Idle, bus parked at zero
      o_c_valid <= 1'b0;
      o_addr_c <= '0;
      o_data_c.flat <= '0;
    end
  end

endmodule

/* source/matmul_top.sv */
`timescale 1ns/1ps

module matmul_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_start,
  input  matmul_pkg::addr_t   i_addr_a,
  input  matmul_pkg::addr_t   i_addr_b,
  input  matmul_pkg::addr_t   i_addr_c,
  input  matmul_pkg::stride_t i_stride_a,
  input  matmul_pkg::stride_t i_stride_b,
  input  matmul_pkg::stride_t i_stride_c,
  input  logic [matmul_pkg::MM_N*matmul_pkg::DATA_W-1:0] i_data_a,
  input  logic [matmul_pkg::MM_N*matmul_pkg::DATA_W-1:0] i_data_b,
  input  matmul_pkg::mask_t   i_mask_a_rows,
  input  matmul_pkg::mask_t   i_mask_inner,
  input  matmul_pkg::mask_t   i_mask_b_cols,
  output matmul_pkg::addr_t   o_addr_a,
  output matmul_pkg::addr_t   o_addr_b,
  output matmul_pkg::addr_t   o_addr_c,
  output logic [matmul_pkg::MM_N*matmul_pkg::DATA_W-1:0] o_data_c,
  output logic                o_c_valid,
  output logic                o_done
);

  matmul_pkg::cnt_t cnt;
  logic latch;

  operand_if u_ops ();
  result_if u_res ();

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  mm_sequencer u_seq (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .o_cnt   (cnt),
    .o_latch (latch),
    .o_done  (o_done)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  operand_feeder u_feed (
    .clk           (clk),
    .reset         (reset),
    .i_start       (i_start),
    .i_cnt         (cnt),
    .i_addr_a      (i_addr_a),
    .i_addr_b      (i_addr_b),
    .i_stride_a    (i_stride_a),
    .i_stride_b    (i_stride_b),
    .i_data_a      (i_data_a),
    .i_data_b      (i_data_b),
    .i_mask_a_rows (i_mask_a_rows),
    .i_mask_inner  (i_mask_inner),
    .i_mask_b_cols (i_mask_b_cols),
    .o_addr_a      (o_addr_a),
    .o_addr_b      (o_addr_b),
    .ops           (u_ops)
  );

  pe_array u_grid (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .ops     (u_ops),
    .res     (u_res)
  );

  result_drain u_drain (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .i_latch    (latch),
    .i_addr_c   (i_addr_c),
    .i_stride_c (i_stride_c),
    .o_addr_c   (o_addr_c),
    .o_data_c   (o_data_c),
    .o_c_valid  (o_c_valid),
    .res        (u_res)
  );

endmodule

/* dv/matmul_assert.sv */
`timescale 1ns/1ps

module matmul_assert (
  input logic clk,
  input logic reset,
  input logic i_start,
  input logic o_done,
  input logic o_c_valid
);

  // Done is a single-cycle pulse
  done_single: assert property (@(posedge clk) disable iff (reset)
    o_done |=> !o_done)
    else $error("o_done stayed high for more than one cycle");

  // Four C beats at most per run
  valid_run: assert property (@(posedge clk) disable iff (reset)
    $rose(o_c_valid) |-> ##4 !o_c_valid)
    else $error("o_c_valid stayed high for more than four cycles");

  // Outputs reflect the start level of the previous edge
  idle_quiet: assert property (@(posedge clk) disable iff (reset)
    !$past(i_start) |-> (!o_done && !o_c_valid))
    else $error("o_done or o_c_valid high while i_start is low");

endmodule

bind matmul_top matmul_assert u_assert (
  .clk       (clk),
  .reset     (reset),
  .i_start   (i_start),
  .o_done    (o_done),
  .o_c_valid (o_c_valid)
);

/* dv/tb_matmul.sv */
`timescale 1ns/1ps

module tb_matmul;

  localparam int N = matmul_pkg::MM_N;
  localparam int MEM_WORDS = 1 << matmul_pkg::ADDR_W;
  localparam int NUM_TESTS = 9;
  localparam int CLK_PERIOD = 10;
  // Cycle budget per table row, also the per-run wait limit
  localparam int CYCLES_PER_TEST = 40;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + 50;

  localparam int MODE_IDENT = 0;
  localparam int MODE_FIXED = 1;
  localparam int MODE_RANDOM = 2;
  localparam int MODE_EXTREME = 3;

  logic clk;
  logic reset;
  logic i_start;
  matmul_pkg::addr_t i_addr_a;
  matmul_pkg::addr_t i_addr_b;
  matmul_pkg::addr_t i_addr_c;
  matmul_pkg::stride_t i_stride_a;
  matmul_pkg::stride_t i_stride_b;
  matmul_pkg::stride_t i_stride_c;
  logic [31:0] i_data_a;
  logic [31:0] i_data_b;
  matmul_pkg::mask_t i_mask_a_rows;
  matmul_pkg::mask_t i_mask_inner;
  matmul_pkg::mask_t i_mask_b_cols;
  matmul_pkg::addr_t o_addr_a;
  matmul_pkg::addr_t o_addr_b;
  matmul_pkg::addr_t o_addr_c;
  logic [31:0] o_data_c;
  logic o_c_valid;
  logic o_done;

  // Stimulus table, one entry per run
  string t_name [NUM_TESTS];
  matmul_pkg::addr_t t_base_a [NUM_TESTS];
  matmul_pkg::addr_t t_base_b [NUM_TESTS];
  matmul_pkg::addr_t t_base_c [NUM_TESTS];
  matmul_pkg::stride_t t_stride_a [NUM_TESTS];
  matmul_pkg::stride_t t_stride_b [NUM_TESTS];
  matmul_pkg::stride_t t_stride_c [NUM_TESTS];
  matmul_pkg::mask_t t_mask_a [NUM_TESTS];
  matmul_pkg::mask_t t_mask_k [NUM_TESTS];
  matmul_pkg::mask_t t_mask_b [NUM_TESTS];
  int t_mode [NUM_TESTS];
  int n_rows;

  // Memory models and matrices of the current run
  logic [31:0] mem_a [MEM_WORDS];
  logic [31:0] mem_b [MEM_WORDS];
  logic signed [7:0] mat_a [N][N];
  logic signed [7:0] mat_b [N][N];
  logic signed [7:0] exp_c [N][N];
  logic [31:0] lfsr_q = 32'h504b;

  // Monitor state
  matmul_pkg::addr_t rd_addr_a;
  matmul_pkg::addr_t rd_addr_b;
  int fetch_seen;
  matmul_pkg::addr_t fetch_a [$];
  matmul_pkg::addr_t fetch_b [$];
  matmul_pkg::addr_t c_addr [$];
  logic [31:0] c_data [$];
  int done_pulses;
  int beats_at_done;

  int data_errors;
  int addr_errors;
  int ctrl_errors;

  matmul_top uut (
    .clk           (clk),
    .reset         (reset),
    .i_start       (i_start),
    .i_addr_a      (i_addr_a),
    .i_addr_b      (i_addr_b),
    .i_addr_c      (i_addr_c),
    .i_stride_a    (i_stride_a),
    .i_stride_b    (i_stride_b),
    .i_stride_c    (i_stride_c),
    .i_data_a      (i_data_a),
    .i_data_b      (i_data_b),
    .i_mask_a_rows (i_mask_a_rows),
    .i_mask_inner  (i_mask_inner),
    .i_mask_b_cols (i_mask_b_cols),
    .o_addr_a      (o_addr_a),
    .o_addr_b      (o_addr_b),
    .o_addr_c      (o_addr_c),
    .o_data_c      (o_data_c),
    .o_c_valid     (o_c_valid),
    .o_done        (o_done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic add_row(string name, matmul_pkg::addr_t ba, matmul_pkg::addr_t bb,
                         matmul_pkg::addr_t bc, matmul_pkg::stride_t sa,
                         matmul_pkg::stride_t sb, matmul_pkg::stride_t sc,
                         matmul_pkg::mask_t ma, matmul_pkg::mask_t mk,
                         matmul_pkg::mask_t mb, int mode);
    t_name[n_rows] = name;
    t_base_a[n_rows] = ba;
    t_base_b[n_rows] = bb;
    t_base_c[n_rows] = bc;
    t_stride_a[n_rows] = sa;
    t_stride_b[n_rows] = sb;
    t_stride_c[n_rows] = sc;
    t_mask_a[n_rows] = ma;
    t_mask_k[n_rows] = mk;
    t_mask_b[n_rows] = mb;
    t_mode[n_rows] = mode;
    n_rows++;
  endtask

  task automatic fill_table();
    n_rows = 0;
    //      name               base_a base_b base_c  sa    sb    sc   m_a  m_k  m_b
    add_row("identity",        'h000, 'h100, 'h200, 'h01, 'h01, 'h01, 'hf, 'hf, 'hf, MODE_IDENT);
    add_row("fixed",           'h040, 'h140, 'h240, 'h01, 'h01, 'h01, 'hf, 'hf, 'hf, MODE_FIXED);
    add_row("random_open",     'h010, 'h120, 'h230, 'h01, 'h01, 'h01, 'hf, 'hf, 'hf, MODE_RANDOM);
    add_row("random_open2",    'h300, 'h400, 'h500, 'h02, 'h02, 'h02, 'hf, 'hf, 'hf, MODE_RANDOM);
    add_row("extreme",         'h020, 'h130, 'h250, 'h01, 'h01, 'h01, 'hf, 'hf, 'hf, MODE_EXTREME);
    add_row("mask_rows",       'h050, 'h150, 'h260, 'h01, 'h01, 'h01, 'ha, 'hf, 'hf, MODE_RANDOM);
    add_row("mask_cols_inner", 'h060, 'h160, 'h270, 'h01, 'h01, 'h01, 'hf, 'h6, 'hd, MODE_RANDOM);
    // Address wrap past the top of the 11-bit space
    add_row("stride_wrap",     'h3f0, 'h7f0, 'h555, 'h25, 'hc3, 'h11, 'hf, 'hf, 'hf, MODE_RANDOM);
    add_row("stride_masks",    'h123, 'h456, 'h789, 'h40, 'hff, 'h7f, 'h5, 'hb, 'he, MODE_RANDOM);
  endtask

  // Galois LFSR, one step per random bit
  function automatic logic next_rand_bit();
    logic lsb;
    lsb = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'hD000_0001;
    end
    return lsb;
  endfunction

  function automatic logic signed [7:0] rand_elem();
    logic [7:0] v;
    for (int b = 0; b < 8; b++) begin
      v[b] = next_rand_bit();
    end
    return v;
  endfunction

  // Odd multiplier is a bijection, so every address gets its own word
  function automatic logic [31:0] fill_word(int addr, logic [31:0] salt);
    return (32'(addr) * 32'h9E37_79B1) ^ salt;
  endfunction

  function automatic matmul_pkg::addr_t step_addr(matmul_pkg::addr_t base,
                                                  matmul_pkg::stride_t stride, int k);
    return matmul_pkg::addr_t'(int'(base) + k * int'(stride));
  endfunction

  // Clamp one product to the signed 8-bit range
  function automatic int sat_term(int p);
    if (p > 127) begin
      return 127;
    end
    if (p < -128) begin
      return -128;
    end
    return p;
  endfunction

  task automatic build_matrices(int mode);
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        case (mode)
          MODE_IDENT: begin
            mat_a[i][k] = (i == k) ? 8'sd1 : 8'sd0;
            mat_b[i][k] = 8'(i * 37 + k * 11 - 60);
          end
          MODE_FIXED: begin
            mat_a[i][k] = 8'(i * 23 - k * 9 + 5);
            mat_b[i][k] = 8'(i * 37 + k * 11 - 60);
          end
          MODE_RANDOM: begin
            mat_a[i][k] = rand_elem();
            mat_b[i][k] = rand_elem();
          end
          default: begin
            // Only the two range ends, so every product saturates
            mat_a[i][k] = ((i + k) % 2 == 0) ? -8'sd128 : 8'sd127;
            mat_b[i][k] = ((i + k) % 3 == 0) ? -8'sd128 : 8'sd127;
          end
        endcase
      end
    end
  endtask

  // Wrapping 8-bit sum of saturated products, masked terms left out
  task automatic compute_expected(int t);
    int acc;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        acc = 0;
        for (int k = 0; k < N; k++) begin
          if (t_mask_a[t][i] && t_mask_b[t][j] && t_mask_k[t][k]) begin
            acc += sat_term(int'(mat_a[i][k]) * int'(mat_b[k][j]));
          end
        end
        exp_c[i][j] = 8'(acc);
      end
    end
  endtask

  // A word k is column k of A, B word k is row k of B
  task automatic load_memories(int t);
    logic [31:0] word_a;
    logic [31:0] word_b;
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem_a[w] = fill_word(w, 32'hA5A5_0000);
      mem_b[w] = fill_word(w, 32'h3C3C_0000);
    end
    for (int k = 0; k < N; k++) begin
      for (int r = 0; r < N; r++) begin
        word_a[8*r +: 8] = mat_a[r][k];
        word_b[8*r +: 8] = mat_b[k][r];
      end
      mem_a[step_addr(t_base_a[t], t_stride_a[t], k)] = word_a;
      mem_b[step_addr(t_base_b[t], t_stride_b[t], k)] = word_b;
    end
  endtask

  ////////////////////////////////////////
  // Memory models and output monitor
  ////////////////////////////////////////

  // Address at the falling edge is the one the next rising edge reads
  always @(negedge clk) begin
    rd_addr_a = o_addr_a;
    rd_addr_b = o_addr_b;
  end

  // One-cycle synchronous read, data driven 1 ns after the edge
  always @(posedge clk) begin
    #1;
    i_data_a = mem_a[rd_addr_a];
    i_data_b = mem_b[rd_addr_b];
  end

  // First four cycles of a run are the fetch cycles
  always @(negedge clk) begin
    if (!i_start) begin
      fetch_seen = 0;
    end else if (fetch_seen < N) begin
      fetch_a.push_back(o_addr_a);
      fetch_b.push_back(o_addr_b);
      fetch_seen++;
    end
    if (o_c_valid) begin
      c_addr.push_back(o_addr_c);
      c_data.push_back(o_data_c);
    end
    if (o_done) begin
      done_pulses++;
      beats_at_done = c_addr.size();
    end
  end

  ////////////////////////////////////////
  // Run and check
  ////////////////////////////////////////

  task automatic check_run(int t);
    matmul_pkg::addr_t exp_addr;
    logic signed [7:0] got;
    if (fetch_a.size() != N || fetch_b.size() != N) begin
      $display("%s: saw %0d A and %0d B fetch cycles instead of 4", t_name[t],
               fetch_a.size(), fetch_b.size());
      ctrl_errors++;
    end else begin
      for (int k = 0; k < N; k++) begin
        exp_addr = step_addr(t_base_a[t], t_stride_a[t], k);
        if (fetch_a[k] != exp_addr) begin
          $display("ERROR %s: A fetch %0d expected %h, actual %h", t_name[t], k,
                   exp_addr, fetch_a[k]);
          addr_errors++;
        end
        exp_addr = step_addr(t_base_b[t], t_stride_b[t], k);
        if (fetch_b[k] != exp_addr) begin
          $display("ERROR %s: B fetch %0d expected %h, actual %h", t_name[t], k,
                   exp_addr, fetch_b[k]);
          addr_errors++;
        end
      end
    end
    if (done_pulses != 1) begin
      $display("%s: o_done pulsed %0d times in one run", t_name[t], done_pulses);
      ctrl_errors++;
    end
    if (done_pulses > 0 && beats_at_done != N) begin
      $display("%s: %0d C beats came before o_done instead of 4", t_name[t], beats_at_done);
      ctrl_errors++;
    end
    if (c_addr.size() != N) begin
      $display("%s: run gave %0d C beats instead of 4", t_name[t], c_addr.size());
      ctrl_errors++;
    end else begin
      for (int j = 0; j < N; j++) begin
        exp_addr = step_addr(t_base_c[t], t_stride_c[t], j);
        if (c_addr[j] != exp_addr) begin
          $display("ERROR %s: C beat %0d address expected %h, actual %h", t_name[t], j,
                   exp_addr, c_addr[j]);
          addr_errors++;
        end
        for (int i = 0; i < N; i++) begin
          got = c_data[j][8*i +: 8];
          if (got != exp_c[i][j]) begin
            $display("ERROR %s: C[%0d][%0d] expected %0d, actual %0d", t_name[t], i, j,
                     exp_c[i][j], got);
            data_errors++;
          end
        end
      end
    end
  endtask

  task automatic run_test(int t);
    int waited;
    logic seen;
    build_matrices(t_mode[t]);
    compute_expected(t);
    @(posedge clk);
    #1;
    load_memories(t);
    i_addr_a = t_base_a[t];
    i_addr_b = t_base_b[t];
    i_addr_c = t_base_c[t];
    i_stride_a = t_stride_a[t];
    i_stride_b = t_stride_b[t];
    i_stride_c = t_stride_c[t];
    i_mask_a_rows = t_mask_a[t];
    i_mask_inner = t_mask_k[t];
    i_mask_b_cols = t_mask_b[t];
    fetch_a.delete();
    fetch_b.delete();
    c_addr.delete();
    c_data.delete();
    done_pulses = 0;
    beats_at_done = 0;
    // One edge with start low loads the bases into the feeder
    @(posedge clk);
    #1;
    i_start = 1'b1;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < CYCLES_PER_TEST) begin
      @(negedge clk);
      seen = o_done;
      waited++;
    end
    if (!seen) begin
      $display("%s: o_done did not pulse within %0d cycles of start", t_name[t],
               CYCLES_PER_TEST);
      ctrl_errors++;
    end
    @(posedge clk);
    #1;
    i_start = 1'b0;
    repeat (2) @(posedge clk);
    check_run(t);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    i_start = 1'b0;
    i_addr_a = '0;
    i_addr_b = '0;
    i_addr_c = '0;
    i_stride_a = '0;
    i_stride_b = '0;
    i_stride_c = '0;
    i_data_a = '0;
    i_data_b = '0;
    i_mask_a_rows = '0;
    i_mask_inner = '0;
    i_mask_b_cols = '0;
    fetch_seen = 0;
    done_pulses = 0;
    beats_at_done = 0;
    data_errors = 0;
    addr_errors = 0;
    ctrl_errors = 0;
    fill_table();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    if (o_done || o_c_valid || o_data_c != '0) begin
      $display("Outputs not idle after reset: done %b, valid %b, data %h", o_done,
               o_c_valid, o_data_c);
      ctrl_errors++;
    end
    for (int t = 0; t < n_rows; t++) begin
      run_test(t);
    end
    $display("Error counts: data %0d, address %0d, control %0d", data_errors,
             addr_errors, ctrl_errors);
    if (data_errors + addr_errors + ctrl_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* project.f */
source/matmul_pkg.sv
source/matmul_if.sv
source/mm_sequencer.sv
source/operand_feeder.sv
source/mac_pe.sv
source/pe_array.sv
source/result_drain.sv
source/matmul_top.sv
dv/matmul_assert.sv
dv/tb_matmul.sv

/* Bender.yml */
package:
  name: matmul

sources:
  - source/matmul_pkg.sv
  - source/matmul_if.sv
  - source/mm_sequencer.sv
  - source/operand_feeder.sv
  - source/mac_pe.sv
  - source/pe_array.sv
  - source/result_drain.sv
  - source/matmul_top.sv
  - target: simulation
    files:
      - dv/matmul_assert.sv
      - dv/tb_matmul.sv
